// File: hdl/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [3:0] lc3b_opcode;

	localparam lc3b_opcode OP_ADD = 4'd1;
	localparam lc3b_opcode OP_AND = 4'd5;
	localparam lc3b_opcode OP_NOT = 4'd9;

	// ROB tag width for the default depth of 8
	localparam int TAG_W = 3;

	// Register form when bit 5 is clear
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm;
		logic [1:0] unused;
		lc3b_reg sr2;
	} lc3b_reg_fmt;

	// Immediate form when bit 5 is set
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm;
		logic [4:0] imm5;
	} lc3b_imm_fmt;

	typedef union packed {
		lc3b_reg_fmt reg_fmt;
		lc3b_imm_fmt imm_fmt;
	} lc3b_instr;

endpackage

`default_nettype wire

// File: hdl/regfile.sv
`default_nettype none

module regfile
	import ooo_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire lc3b_reg src1_reg,
	input wire lc3b_reg src2_reg,
	output lc3b_word src1_value,
	output logic src1_busy,
	output logic [TAG_W-1:0] src1_tag,
	output lc3b_word src2_value,
	output logic src2_busy,
	output logic [TAG_W-1:0] src2_tag,
	input wire logic rename_write,
	input wire lc3b_reg rename_reg,
	input wire logic [TAG_W-1:0] rename_tag,
	input wire logic commit_valid,
	input wire lc3b_reg commit_dest,
	input wire lc3b_word commit_value,
	input wire logic [TAG_W-1:0] commit_tag
);

	lc3b_word value [8];
	logic [7:0] busy;
	logic [TAG_W-1:0] tag [8];

	// Combinational read ports for issue
	assign src1_value = value[src1_reg];
	assign src1_busy = busy[src1_reg];
	assign src1_tag = tag[src1_reg];
	assign src2_value = value[src2_reg];
	assign src2_busy = busy[src2_reg];
	assign src2_tag = tag[src2_reg];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= '0;
			for (int i = 0; i < 8; i++)
			begin
				value[i] <= '0;
				tag[i] <= '0;
			end
		end
		else
		begin
			if (commit_valid)
			begin
				value[commit_dest] <= commit_value;
				// A younger rename keeps the register busy
				if (tag[commit_dest] == commit_tag)
					busy[commit_dest] <= 1'b0;
			end
			// Rename last so it wins over a commit to the same register
			if (rename_write)
			begin
				busy[rename_reg] <= 1'b1;
				tag[rename_reg] <= rename_tag;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/reorder_buffer.sv
`default_nettype none

module reorder_buffer
	import ooo_pkg::*;
#(
	parameter int ROB_DEPTH = 8
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic rob_alloc,
	input wire lc3b_reg rob_dest,
	output logic [TAG_W-1:0] rob_tail,
	output logic rob_full,
	input wire logic [TAG_W-1:0] rob_src1_tag,
	input wire logic [TAG_W-1:0] rob_src2_tag,
	output logic rob_src1_ready,
	output lc3b_word rob_src1_value,
	output logic rob_src2_ready,
	output lc3b_word rob_src2_value,
	input wire logic cdb_valid,
	input wire logic [TAG_W-1:0] cdb_tag,
	input wire lc3b_word cdb_value,
	output logic commit_valid,
	output lc3b_reg commit_dest,
	output lc3b_word commit_value,
	output logic [TAG_W-1:0] commit_tag
);

	localparam int CNT_W = $clog2(ROB_DEPTH + 1);

	lc3b_reg dest [ROB_DEPTH];
	lc3b_word value [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] ready;
	logic [TAG_W-1:0] head;
	logic [TAG_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic retire;

	// Pointer increment with wrap at the configured depth
	function automatic logic [TAG_W-1:0] next_ptr(input logic [TAG_W-1:0] ptr);
		if (ptr == TAG_W'(ROB_DEPTH - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	assign retire = (count != '0) && ready[head];
	assign rob_full = (count == CNT_W'(ROB_DEPTH));
	assign rob_tail = tail;

	// Operand forwarding for issue
	assign rob_src1_ready = ready[rob_src1_tag];
	assign rob_src1_value = value[rob_src1_tag];
	assign rob_src2_ready = ready[rob_src2_tag];
	assign rob_src2_value = value[rob_src2_tag];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			ready <= '0;
			commit_valid <= 1'b0;
		end
		else
		begin
			if (cdb_valid)
				ready[cdb_tag] <= 1'b1;
			if (rob_alloc)
			begin
				ready[tail] <= 1'b0;
				tail <= next_ptr(tail);
			end
			// Retired entries keep their ready bit and value until reallocated,
			// since the regfile write lands one cycle after retirement
			if (retire)
				head <= next_ptr(head);
			commit_valid <= retire;
			count <= count + CNT_W'(rob_alloc) - CNT_W'(retire);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rob_alloc)
			dest[tail] <= rob_dest;
		if (cdb_valid)
			value[cdb_tag] <= cdb_value;
		if (retire)
		begin
			commit_dest <= dest[head];
			commit_value <= value[head];
			commit_tag <= head;
		end
	end

endmodule

`default_nettype wire

// File: hdl/alu_rs_unit.sv
`default_nettype none

module alu_rs_unit
	import ooo_pkg::*;
#(
	parameter int NUM_RS = 3
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic rs_write,
	input wire logic [$clog2(NUM_RS)-1:0] rs_id,
	input wire lc3b_opcode rs_op,
	input wire lc3b_word rs_vj,
	input wire lc3b_word rs_vk,
	input wire logic [TAG_W-1:0] rs_qj,
	input wire logic [TAG_W-1:0] rs_qk,
	input wire logic rs_vj_valid,
	input wire logic rs_vk_valid,
	input wire logic [TAG_W-1:0] rs_dest_tag,
	output logic [NUM_RS-1:0] rs_busy,
	output logic cdb_valid,
	output logic [TAG_W-1:0] cdb_tag,
	output lc3b_word cdb_value
);

	localparam int ID_W = $clog2(NUM_RS);

	lc3b_opcode st_op [NUM_RS];
	lc3b_word st_vj [NUM_RS];
	lc3b_word st_vk [NUM_RS];
	logic [TAG_W-1:0] st_qj [NUM_RS];
	logic [TAG_W-1:0] st_qk [NUM_RS];
	logic [TAG_W-1:0] st_dest [NUM_RS];
	logic [NUM_RS-1:0] st_vj_valid;
	logic [NUM_RS-1:0] st_vk_valid;
	logic [NUM_RS-1:0] st_ready;
	logic sel_valid;
	logic [ID_W-1:0] sel_id;
	lc3b_word alu_out;

	assign st_ready = rs_busy & st_vj_valid & st_vk_valid;

	// Lowest index ready station goes first
	always_comb
	begin
		sel_valid = 1'b0;
		sel_id = '0;
		for (int i = NUM_RS - 1; i >= 0; i--)
		begin
			if (st_ready[i])
			begin
				sel_valid = 1'b1;
				sel_id = ID_W'(i);
			end
		end
	end

	always_comb
	begin
		case (st_op[sel_id])
			OP_AND: alu_out = st_vj[sel_id] & st_vk[sel_id];
			OP_NOT: alu_out = ~st_vj[sel_id];
			// Anything else reaching a station is ADD
			default: alu_out = st_vj[sel_id] + st_vk[sel_id];
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rs_busy <= '0;
			cdb_valid <= 1'b0;
		end
		else
		begin
			cdb_valid <= sel_valid;
			if (sel_valid)
				rs_busy[sel_id] <= 1'b0;
			if (rs_write)
				rs_busy[rs_id] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_RS; i++)
		begin
			if (rs_write && rs_id == ID_W'(i))
			begin
				st_op[i] <= rs_op;
				st_vj[i] <= rs_vj;
				st_vk[i] <= rs_vk;
				st_qj[i] <= rs_qj;
				st_qk[i] <= rs_qk;
				st_vj_valid[i] <= rs_vj_valid;
				st_vk_valid[i] <= rs_vk_valid;
				st_dest[i] <= rs_dest_tag;
			end
			else if (rs_busy[i] && cdb_valid)
			begin
				// Snoop our own broadcast for waiting operands
				if (!st_vj_valid[i] && st_qj[i] == cdb_tag)
				begin
					st_vj[i] <= cdb_value;
					st_vj_valid[i] <= 1'b1;
				end
				if (!st_vk_valid[i] && st_qk[i] == cdb_tag)
				begin
					st_vk[i] <= cdb_value;
					st_vk_valid[i] <= 1'b1;
				end
			end
		end
		if (sel_valid)
		begin
			cdb_tag <= st_dest[sel_id];
			cdb_value <= alu_out;
		end
	end

endmodule

`default_nettype wire

// File: hdl/issue_control.sv
`default_nettype none

module issue_control
	import ooo_pkg::*;
#(
	parameter int ROB_DEPTH = 8,
	parameter int NUM_RS = 3
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic instr_valid,
	input wire lc3b_instr instr,
	input wire lc3b_word src1_value,
	input wire logic src1_busy,
	input wire logic [TAG_W-1:0] src1_tag,
	input wire lc3b_word src2_value,
	input wire logic src2_busy,
	input wire logic [TAG_W-1:0] src2_tag,
	input wire logic rob_src1_ready,
	input wire lc3b_word rob_src1_value,
	input wire logic rob_src2_ready,
	input wire lc3b_word rob_src2_value,
	input wire logic rob_full,
	input wire logic [TAG_W-1:0] rob_tail,
	input wire logic [NUM_RS-1:0] rs_busy,
	input wire logic cdb_valid,
	input wire logic [TAG_W-1:0] cdb_tag,
	input wire lc3b_word cdb_value,
	output logic issue_ready,
	output lc3b_reg src1_reg,
	output lc3b_reg src2_reg,
	output logic [TAG_W-1:0] rob_src1_tag,
	output logic [TAG_W-1:0] rob_src2_tag,
	output logic rs_write,
	output logic [$clog2(NUM_RS)-1:0] rs_id,
	output lc3b_opcode rs_op,
	output lc3b_word rs_vj,
	output lc3b_word rs_vk,
	output logic [TAG_W-1:0] rs_qj,
	output logic [TAG_W-1:0] rs_qk,
	output logic rs_vj_valid,
	output logic rs_vk_valid,
	output logic [TAG_W-1:0] rs_dest_tag,
	output logic rob_alloc,
	output lc3b_reg rob_dest,
	output logic rename_write,
	output lc3b_reg rename_reg,
	output logic [TAG_W-1:0] rename_tag
);

	localparam int ID_W = $clog2(NUM_RS);

	lc3b_opcode op;
	logic supported;
	logic use_imm;
	lc3b_word imm_sext;
	logic free_any;
	logic [ID_W-1:0] free_id;
	logic accept;

	// Operand lookup order is regfile, ROB, CDB in this cycle, then wait on the tag
	function automatic void resolve(
		input logic busy,
		input lc3b_word reg_value,
		input logic [TAG_W-1:0] tag,
		input logic rob_ready,
		input lc3b_word rob_value,
		input logic bus_valid,
		input logic [TAG_W-1:0] bus_tag,
		input lc3b_word bus_value,
		output lc3b_word value,
		output logic [TAG_W-1:0] wait_tag,
		output logic valid
	);
		value = reg_value;
		wait_tag = tag;
		valid = 1'b1;
		if (busy)
		begin
			if (rob_ready)
				value = rob_value;
			else if (bus_valid && bus_tag == tag)
				value = bus_value;
			else
			begin
				value = '0;
				valid = 1'b0;
			end
		end
	endfunction

	assign op = instr.reg_fmt.opcode;
	assign supported = (op == OP_ADD) || (op == OP_AND) || (op == OP_NOT);
	assign use_imm = instr.reg_fmt.imm;
	assign imm_sext = {{11{instr.imm_fmt.imm5[4]}}, instr.imm_fmt.imm5};

	assign src1_reg = instr.reg_fmt.sr1;
	assign src2_reg = instr.reg_fmt.sr2;
	assign rob_src1_tag = src1_tag;
	assign rob_src2_tag = src2_tag;

	// Lowest free station
	always_comb
	begin
		free_any = 1'b0;
		free_id = '0;
		for (int i = NUM_RS - 1; i >= 0; i--)
		begin
			if (!rs_busy[i])
			begin
				free_any = 1'b1;
				free_id = ID_W'(i);
			end
		end
	end

	// Stall when the ROB is full or no station is free
	assign issue_ready = !rob_full && free_any;

	// Unsupported opcodes are dropped here and never allocate anything
	assign accept = instr_valid && issue_ready && supported;

	always_comb
	begin
		resolve(src1_busy, src1_value, src1_tag, rob_src1_ready, rob_src1_value,
			cdb_valid, cdb_tag, cdb_value, rs_vj, rs_qj, rs_vj_valid);
		if (op == OP_NOT)
		begin
			rs_vk = '0;
			rs_qk = '0;
			rs_vk_valid = 1'b1;
		end
		else if (use_imm)
		begin
			rs_vk = imm_sext;
			rs_qk = '0;
			rs_vk_valid = 1'b1;
		end
		else
			resolve(src2_busy, src2_value, src2_tag, rob_src2_ready, rob_src2_value,
				cdb_valid, cdb_tag, cdb_value, rs_vk, rs_qk, rs_vk_valid);
	end

	assign rs_write = accept;
	assign rs_id = free_id;
	assign rs_op = op;
	assign rs_dest_tag = rob_tail;

	assign rob_alloc = accept;
	assign rob_dest = instr.reg_fmt.dr;

	assign rename_write = accept;
	assign rename_reg = instr.reg_fmt.dr;
	assign rename_tag = rob_tail;

endmodule

`default_nettype wire

// File: hdl/ooo_core.sv
`default_nettype none

module ooo_core
	import ooo_pkg::*;
#(
	parameter int ROB_DEPTH = 8,
	parameter int NUM_RS = 3
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic instr_valid,
	input wire lc3b_instr instr,
	output logic issue_ready,
	output logic commit_valid,
	output lc3b_reg commit_dest,
	output lc3b_word commit_value
);

	// Regfile read ports
	lc3b_reg src1_reg;
	lc3b_reg src2_reg;
	lc3b_word src1_value;
	lc3b_word src2_value;
	logic src1_busy;
	logic src2_busy;
	logic [TAG_W-1:0] src1_tag;
	logic [TAG_W-1:0] src2_tag;

	// ROB lookup and allocation
	logic [TAG_W-1:0] rob_src1_tag;
	logic [TAG_W-1:0] rob_src2_tag;
	logic rob_src1_ready;
	logic rob_src2_ready;
	lc3b_word rob_src1_value;
	lc3b_word rob_src2_value;
	logic rob_full;
	logic [TAG_W-1:0] rob_tail;
	logic rob_alloc;
	lc3b_reg rob_dest;

	// Station write
	logic rs_write;
	logic [$clog2(NUM_RS)-1:0] rs_id;
	lc3b_opcode rs_op;
	lc3b_word rs_vj;
	lc3b_word rs_vk;
	logic [TAG_W-1:0] rs_qj;
	logic [TAG_W-1:0] rs_qk;
	logic rs_vj_valid;
	logic rs_vk_valid;
	logic [TAG_W-1:0] rs_dest_tag;
	logic [NUM_RS-1:0] rs_busy;

	// Rename, CDB and commit
	logic rename_write;
	lc3b_reg rename_reg;
	logic [TAG_W-1:0] rename_tag;
	logic cdb_valid;
	logic [TAG_W-1:0] cdb_tag;
	lc3b_word cdb_value;
	logic [TAG_W-1:0] commit_tag;

	issue_control #(.ROB_DEPTH(ROB_DEPTH), .NUM_RS(NUM_RS)) issue_control
	(
		.clk, .rst, .instr_valid, .instr, .issue_ready,
		.src1_reg, .src1_value, .src1_busy, .src1_tag,
		.src2_reg, .src2_value, .src2_busy, .src2_tag,
		.rob_src1_tag, .rob_src1_ready, .rob_src1_value,
		.rob_src2_tag, .rob_src2_ready, .rob_src2_value,
		.rob_full, .rob_tail, .rob_alloc, .rob_dest,
		.rs_busy, .rs_write, .rs_id, .rs_op, .rs_vj, .rs_vk,
		.rs_qj, .rs_qk, .rs_vj_valid, .rs_vk_valid, .rs_dest_tag,
		.rename_write, .rename_reg, .rename_tag,
		.cdb_valid, .cdb_tag, .cdb_value
	);

	regfile regfile
	(
		.clk, .rst,
		.src1_reg, .src1_value, .src1_busy, .src1_tag,
		.src2_reg, .src2_value, .src2_busy, .src2_tag,
		.rename_write, .rename_reg, .rename_tag,
		.commit_valid, .commit_dest, .commit_value, .commit_tag
	);

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) reorder_buffer
	(
		.clk, .rst, .rob_alloc, .rob_dest, .rob_tail, .rob_full,
		.rob_src1_tag, .rob_src1_ready, .rob_src1_value,
		.rob_src2_tag, .rob_src2_ready, .rob_src2_value,
		.cdb_valid, .cdb_tag, .cdb_value,
		.commit_valid, .commit_dest, .commit_value, .commit_tag
	);

	alu_rs_unit #(.NUM_RS(NUM_RS)) alu_rs_unit
	(
		.clk, .rst, .rs_write, .rs_id, .rs_op, .rs_vj, .rs_vk,
		.rs_qj, .rs_qk, .rs_vj_valid, .rs_vk_valid, .rs_dest_tag,
		.rs_busy, .cdb_valid, .cdb_tag, .cdb_value
	);

endmodule

`default_nettype wire

// File: sim/ooo_core_sva.sv
`default_nettype none

module ooo_core_sva
	import ooo_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic instr_valid,
	input wire logic issue_ready,
	input wire logic commit_valid,
	input wire lc3b_reg commit_dest,
	input wire lc3b_word commit_value
);

	// Quiet through reset and on the first cycle after it
	commit_quiet_in_reset: assert property (@(posedge clk) rst |=> !commit_valid)
		else $error("commit_valid high during or right after reset");

	// Source may only strobe while the core can take it
	strobe_only_when_ready: assert property (
		@(posedge clk) disable iff (rst)
		instr_valid |-> issue_ready
	)
		else $error("instr_valid high while issue_ready is low");

	commit_fields_known: assert property (
		@(posedge clk) disable iff (rst)
		commit_valid |-> !$isunknown({commit_dest, commit_value})
	)
		else $error("commit_dest or commit_value unknown on a commit");

endmodule

bind ooo_core ooo_core_sva sva (.*);

`default_nettype wire

// File: sim/ooo_core_tb.sv
`default_nettype none

module ooo_core_tb
	import ooo_pkg::*;
();

	localparam int WAIT_LIMIT = 200;
	localparam int RANDOM_COUNT = 200;
	localparam int DISCARD_COUNT = 60;

	logic clk;
	logic rst;
	logic instr_valid;
	lc3b_instr instr;
	logic issue_ready;
	logic commit_valid;
	lc3b_reg commit_dest;
	lc3b_word commit_value;

	// Program-order reference state
	lc3b_word model_reg [8];
	lc3b_reg exp_dest [$];
	lc3b_word exp_value [$];
	lc3b_reg mon_dest;
	lc3b_word mon_value;
	lc3b_word last_value;
	int value_errors;
	int other_errors;
	int commit_count;

	ooo_core #(.ROB_DEPTH(8), .NUM_RS(3)) dut
	(
		.clk, .rst, .instr_valid, .instr,
		.issue_ready, .commit_valid, .commit_dest, .commit_value
	);

	always #20 clk = ~clk;

	function automatic logic is_supported(input lc3b_opcode op);
		return (op == OP_ADD) || (op == OP_AND) || (op == OP_NOT);
	endfunction

	function automatic lc3b_instr reg_form(input lc3b_opcode op, input lc3b_reg dr,
		input lc3b_reg sr1, input lc3b_reg sr2);
		lc3b_instr w;
		w.reg_fmt.opcode = op;
		w.reg_fmt.dr = dr;
		w.reg_fmt.sr1 = sr1;
		w.reg_fmt.imm = 1'b0;
		w.reg_fmt.unused = 2'b00;
		w.reg_fmt.sr2 = sr2;
		return w;
	endfunction

	function automatic lc3b_instr imm_form(input lc3b_opcode op, input lc3b_reg dr,
		input lc3b_reg sr1, input int imm);
		lc3b_instr w;
		w.imm_fmt.opcode = op;
		w.imm_fmt.dr = dr;
		w.imm_fmt.sr1 = sr1;
		w.imm_fmt.imm = 1'b1;
		w.imm_fmt.imm5 = 5'(imm);
		return w;
	endfunction

	// LC-3b NOT keeps the low six bits all ones
	function automatic lc3b_instr not_form(input lc3b_reg dr, input lc3b_reg sr1);
		return imm_form(OP_NOT, dr, sr1, -1);
	endfunction

	function automatic lc3b_instr random_instr(input logic allow_other);
		lc3b_opcode op;
		lc3b_reg dr;
		lc3b_reg sr1;
		case ($urandom_range(0, 2))
			0: op = OP_ADD;
			1: op = OP_AND;
			default: op = OP_NOT;
		endcase
		if (allow_other && $urandom_range(0, 2) == 0)
		begin
			op = 4'($urandom_range(0, 15));
			while (is_supported(op))
				op = 4'($urandom_range(0, 15));
		end
		dr = 3'($urandom_range(0, 7));
		sr1 = 3'($urandom_range(0, 7));
		if (op == OP_NOT)
			return not_form(dr, sr1);
		else if ($urandom_range(0, 1) == 1)
			return imm_form(op, dr, sr1, int'($urandom_range(0, 31)) - 16);
		else
			return reg_form(op, dr, sr1, 3'($urandom_range(0, 7)));
	endfunction

	// ISA semantics applied in issue order
	task automatic model_issue(input lc3b_instr w);
		lc3b_word a;
		lc3b_word b;
		lc3b_word r;
		a = model_reg[w.reg_fmt.sr1];
		if (w.imm_fmt.imm)
			b = 16'($signed(w.imm_fmt.imm5));
		else
			b = model_reg[w.reg_fmt.sr2];
		case (w.reg_fmt.opcode)
			OP_ADD: r = a + b;
			OP_AND: r = a & b;
			default: r = ~a;
		endcase
		model_reg[w.reg_fmt.dr] = r;
		exp_dest.push_back(w.reg_fmt.dr);
		exp_value.push_back(r);
	endtask

	task automatic finish_run();
		$display("Value errors: %0d, other errors: %0d, commits: %0d",
			value_errors, other_errors, commit_count);
		if (value_errors == 0 && other_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!issue_ready && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!issue_ready)
		begin
			other_errors++;
			$display("Timeout: issue_ready stayed low for %0d cycles", WAIT_LIMIT);
			finish_run();
		end
	endtask

	task automatic send(input lc3b_instr w);
		@(negedge clk);
		instr_valid = 1'b0;
		wait_ready();
		instr = w;
		instr_valid = 1'b1;
		if (is_supported(w.reg_fmt.opcode))
			model_issue(w);
	endtask

	task automatic drain_commits();
		int cycles;
		@(negedge clk);
		instr_valid = 1'b0;
		cycles = 0;
		while (exp_dest.size() != 0 && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (exp_dest.size() != 0)
		begin
			other_errors++;
			$display("Timeout: %0d commits still missing after %0d cycles",
				exp_dest.size(), WAIT_LIMIT);
			finish_run();
		end
		// A few quiet cycles so a stray commit shows up
		repeat (4) @(negedge clk);
	endtask

	// Commit monitor
	always @(negedge clk)
	begin
		if (!rst && commit_valid)
		begin
			commit_count++;
			last_value = commit_value;
			assert (exp_dest.size() != 0)
			else
			begin
				other_errors++;
				$display("Commit at time %0t with no instruction outstanding", $time);
			end
			if (exp_dest.size() != 0)
			begin
				mon_dest = exp_dest.pop_front();
				mon_value = exp_value.pop_front();
				assert (commit_dest === mon_dest && commit_value === mon_value)
				else
				begin
					value_errors++;
					$display("ERR %0t: commit R%0d = %h, expected R%0d = %h",
						$time, commit_dest, commit_value, mon_dest, mon_value);
				end
			end
		end
	end

	task automatic reset_and_imm();
		assert (issue_ready === 1'b1)
		else
		begin
			value_errors++;
			$display("ERR %0t: issue_ready is %b after reset", $time, issue_ready);
		end
		send(imm_form(OP_ADD, 3'd1, 3'd0, -3));
		drain_commits();
		assert (last_value === 16'hfffd)
		else
		begin
			value_errors++;
			$display("ERR %0t: ADD R1,R0,#-3 gave %h", $time, last_value);
		end
	endtask

	task automatic independent_ops();
		send(imm_form(OP_ADD, 3'd2, 3'd0, 13));
		send(imm_form(OP_ADD, 3'd3, 3'd0, -6));
		send(imm_form(OP_ADD, 3'd4, 3'd0, 10));
		send(reg_form(OP_ADD, 3'd5, 3'd2, 3'd3));
		send(reg_form(OP_AND, 3'd6, 3'd2, 3'd3));
		send(not_form(3'd7, 3'd4));
		send(imm_form(OP_AND, 3'd1, 3'd3, 15));
		send(imm_form(OP_AND, 3'd0, 3'd4, -8));
		drain_commits();
	endtask

	task automatic raw_chains();
		// Same destination reused back to back
		for (int i = 0; i < 6; i++)
			send(imm_form(OP_ADD, 3'd1, 3'd1, 1));
		send(reg_form(OP_ADD, 3'd2, 3'd1, 3'd1));
		send(not_form(3'd3, 3'd2));
		send(reg_form(OP_AND, 3'd2, 3'd3, 3'd2));
		send(reg_form(OP_ADD, 3'd4, 3'd2, 3'd3));
		send(not_form(3'd4, 3'd4));
		send(reg_form(OP_ADD, 3'd4, 3'd4, 3'd1));
		drain_commits();
	endtask

	task automatic fill_capacity();
		int accepted;
		int start;
		int cycles;
		logic saw_full;
		lc3b_instr w;
		accepted = 0;
		start = commit_count;
		saw_full = 1'b0;
		cycles = 0;
		// A chain on R5 keeps every station waiting
		while (!saw_full && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			instr_valid = 1'b0;
			if (issue_ready)
			begin
				if ($urandom_range(0, 1) == 1)
					w = imm_form(OP_ADD, 3'd5, 3'd5, 3);
				else
					w = not_form(3'd5, 3'd5);
				instr = w;
				instr_valid = 1'b1;
				model_issue(w);
				accepted++;
			end
			else
				saw_full = 1'b1;
			cycles++;
		end
		drain_commits();
		assert (saw_full)
		else
		begin
			other_errors++;
			$display("issue_ready never dropped while the core was being filled");
		end
		assert (commit_count - start == accepted)
		else
		begin
			value_errors++;
			$display("ERR %0t: %0d commits for %0d accepted instructions",
				$time, commit_count - start, accepted);
		end
	endtask

	task automatic random_mix();
		for (int n = 0; n < RANDOM_COUNT; n++)
			send(random_instr(1'b0));
		drain_commits();
	endtask

	task automatic discarded_opcodes();
		int start;
		int supported;
		lc3b_instr w;
		start = commit_count;
		supported = 0;
		for (int n = 0; n < DISCARD_COUNT; n++)
		begin
			w = random_instr(1'b1);
			if (is_supported(w.reg_fmt.opcode))
				supported++;
			send(w);
		end
		drain_commits();
		assert (commit_count - start == supported)
		else
		begin
			value_errors++;
			$display("ERR %0t: %0d commits for %0d supported instructions",
				$time, commit_count - start, supported);
		end
	endtask

	initial
	begin
		void'($urandom(32'hd00a));
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		value_errors = 0;
		other_errors = 0;
		commit_count = 0;
		last_value = '0;
		for (int i = 0; i < 8; i++)
			model_reg[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		reset_and_imm();
		independent_ops();
		raw_chains();
		fill_capacity();
		random_mix();
		discarded_opcodes();
		finish_run();
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/ooo_pkg.sv
hdl/regfile.sv
hdl/reorder_buffer.sv
hdl/alu_rs_unit.sv
hdl/issue_control.sv
hdl/ooo_core.sv
sim/ooo_core_sva.sv
sim/ooo_core_tb.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  # RTL, package first
  - files:
      - hdl/ooo_pkg.sv
      - hdl/regfile.sv
      - hdl/reorder_buffer.sv
      - hdl/alu_rs_unit.sv
      - hdl/issue_control.sv
      - hdl/ooo_core.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/ooo_core_sva.sv
      - sim/ooo_core_tb.sv
